/* serdes_test_pkg.sv */
package serdes_test_pkg;

    // Word geometry
    localparam int WORD_W        = 8;                    // Bits per parallel word
    localparam int PHASE_W       = $clog2(WORD_W);       // Bit position counters

    // Reset and blink
    localparam int RST_STRETCH   = 4;                    // Cycles held past rst
    localparam int HB_W          = 24;                   // Heartbeat counter width
    localparam int HEARTBEAT_BIT = 22;                   // Tap driving led[0]

    // Source to serializer flow control
    localparam int CREDITS       = 2;                    // Serializer buffer depth
    localparam int CREDIT_W      = $clog2(CREDITS + 1);  // Holds 0..CREDITS
    localparam int BUF_AW        = $clog2(CREDITS);      // Buffer pointer width

    // Alignment thresholds
    localparam int LOCK_GOOD     = 8;                    // Good run to declare lock
    localparam int GOOD_W        = $clog2(LOCK_GOOD);    // Counts 0..LOCK_GOOD-1
    localparam int UNLOCK_BAD    = 4;                    // Bad run to drop lock
    localparam int BAD_W         = $clog2(UNLOCK_BAD);   // Counts 0..UNLOCK_BAD-1

    // Status
    localparam int ERR_W         = 7;                    // Saturating error count

    // Receive alignment FSM
    typedef enum logic [1:0] {
        HUNT   = 2'd0,   // Searching for word boundary
        VERIFY = 2'd1,   // Candidate boundary under test
        LOCKED = 2'd2    // Boundary confirmed
    } align_state_t;

endpackage

/* reset_heartbeat.sv */
`timescale 1ns/1ps

module reset_heartbeat import serdes_test_pkg::*; (
    input  logic CLK,
    input  logic rst,
    output logic sys_rst,
    output logic heartbeat
);

    logic [RST_STRETCH-1:0] rst_sr;   // Stretch taps, drain toward bit 0
    logic [HB_W-1:0]        hb_cnt;   // Free-running blink counter

    // Refill on rst, then shift zeros in from the top
    always_ff @(posedge CLK) begin
        if (rst) begin
            rst_sr <= '1;             // Arm full stretch
        end else begin
            rst_sr <= rst_sr >> 1;    // One cycle less to go
        end
    end

    // Rises with rst, falls RST_STRETCH cycles after it
    assign sys_rst = rst | rst_sr[0];

    always_ff @(posedge CLK) begin
        if (sys_rst) begin
            hb_cnt <= '0;
        end else begin
            hb_cnt <= hb_cnt + 1'b1;  // Wraps freely
        end
    end

    assign heartbeat = hb_cnt[HEARTBEAT_BIT];  // Slow blink tap

endmodule

/* word_source.sv */
`timescale 1ns/1ps

module word_source import serdes_test_pkg::*; (
    input  logic              CLK,
    input  logic              sys_rst,
    input  logic [WORD_W-1:0] mask,
    input  logic              credit_return,
    output logic [WORD_W-1:0] tx_word,
    output logic              tx_valid
);

    logic [CREDIT_W-1:0] credits;   // Free slots in serializer buffer
    logic [WORD_W-1:0]   pattern;   // Unmasked counter value
    logic                issue;     // Send a word this cycle

    assign issue = (credits != '0);  // Stall when no slot is free

    // Credit accounting and pattern advance
    always_ff @(posedge CLK) begin
        if (sys_rst) begin
            credits  <= CREDIT_W'(CREDITS);   // Whole buffer free
            pattern  <= '0;
            tx_valid <= 1'b0;
        end else begin
            tx_valid <= issue;                // One-cycle pulse per word
            if (issue) begin
                pattern <= pattern + 1'b1;    // Next counter value
            end
            credits <= credits - CREDIT_W'(issue) + CREDIT_W'(credit_return);
        end
    end

    // Word payload
    always_ff @(posedge CLK) begin
        if (issue) begin
            tx_word <= pattern ^ mask;        // Mask with switches
        end
    end

endmodule

/* word_serializer.sv */
`timescale 1ns/1ps

module word_serializer import serdes_test_pkg::*; (
    input  logic              CLK,
    input  logic              sys_rst,
    input  logic [WORD_W-1:0] tx_word,
    input  logic              tx_valid,
    output logic              credit_return,
    output logic              ser_out
);

    logic [WORD_W-1:0]   buf_mem [CREDITS];  // Word buffer
    logic [BUF_AW-1:0]   wr_ptr;             // Next slot to fill
    logic [BUF_AW-1:0]   rd_ptr;             // Oldest word
    logic [CREDIT_W-1:0] buf_cnt;            // Words held
    logic [WORD_W-1:0]   shreg;              // Outgoing word, MSB first
    logic [PHASE_W-1:0]  bit_cnt;            // Bit position in word
    logic                active;             // Shift register holds a word
    logic                word_end;           // Last bit on the line
    logic                load;               // Move buffer head to shifter

    function automatic logic [BUF_AW-1:0] next_ptr(input logic [BUF_AW-1:0] ptr);
        if (ptr == BUF_AW'(CREDITS - 1)) begin
            return '0;                       // Wrap around buffer
        end
        return ptr + 1'b1;
    endfunction

    assign word_end      = active && (bit_cnt == PHASE_W'(WORD_W - 1));
    assign load          = (buf_cnt != '0) && (!active || word_end);
    assign credit_return = load;                      // Slot freed on load
    assign ser_out       = active & shreg[WORD_W-1];  // Low when idle

    // Buffer bookkeeping
    always_ff @(posedge CLK) begin
        if (sys_rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            buf_cnt <= '0;
        end else begin
            if (tx_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (load) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            buf_cnt <= buf_cnt + CREDIT_W'(tx_valid) - CREDIT_W'(load);
        end
    end

    always_ff @(posedge CLK) begin
        if (tx_valid) begin
            buf_mem[wr_ptr] <= tx_word;   // Source never overruns credits
        end
    end

    // Shifter control
    always_ff @(posedge CLK) begin
        if (sys_rst) begin
            active  <= 1'b0;
            bit_cnt <= '0;
        end else if (load) begin
            active  <= 1'b1;              // Back-to-back words
            bit_cnt <= '0;
        end else if (active) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (word_end) begin
                active <= 1'b0;           // Buffer ran dry
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (load) begin
            shreg <= buf_mem[rd_ptr];
        end else begin
            shreg <= shreg << 1;          // Next bit to MSB
        end
    end

endmodule

/* word_deserializer.sv */
`timescale 1ns/1ps

module word_deserializer import serdes_test_pkg::*; (
    input  logic              CLK,
    input  logic              sys_rst,
    input  logic              ser_in,
    input  logic              bitslip,
    output logic [WORD_W-1:0] rx_word,
    output logic              rx_valid
);

    logic [WORD_W-1:0]  shreg;    // Recent line bits, newest at LSB
    logic [PHASE_W-1:0] phase;    // Position inside current word
    logic               strobe;   // Word complete this cycle

    // Slip holds the phase, so a strobe can be deferred too
    assign strobe = (phase == PHASE_W'(WORD_W - 1)) && !bitslip;

    always_ff @(posedge CLK) begin
        shreg <= {shreg[WORD_W-2:0], ser_in};   // Shift every cycle
    end

    // Word boundary tracking
    always_ff @(posedge CLK) begin
        if (sys_rst) begin
            phase    <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= strobe;                 // One pulse per word
            if (!bitslip) begin
                if (phase == PHASE_W'(WORD_W - 1)) begin
                    phase <= '0;
                end else begin
                    phase <= phase + 1'b1;
                end
            end
        end
    end

    // Word payload includes the bit arriving now
    always_ff @(posedge CLK) begin
        if (strobe) begin
            rx_word <= {shreg[WORD_W-2:0], ser_in};
        end
    end

endmodule

/* link_checker.sv */
`timescale 1ns/1ps

module link_checker import serdes_test_pkg::*; (
    input  logic              CLK,
    input  logic              sys_rst,
    input  logic [WORD_W-1:0] mask,
    input  logic [WORD_W-1:0] rx_word,
    input  logic              rx_valid,
    output logic              bitslip,
    output logic              locked,
    output logic [ERR_W-1:0]  err_count
);

    align_state_t      state;      // Alignment FSM
    logic [WORD_W-1:0] mask_q;     // Mask seen last cycle
    logic [WORD_W-1:0] word;       // Received word, unmasked
    logic [WORD_W-1:0] expected;   // Next counter value
    logic              seed_vld;   // HUNT has a seed word
    logic [GOOD_W-1:0] good_cnt;   // Good run in VERIFY
    logic [BAD_W-1:0]  bad_cnt;    // Bad run in LOCKED
    logic              mask_chg;   // Switches moved
    logic              match;      // Word equals expected

    assign word     = rx_word ^ mask;
    assign mask_chg = (mask != mask_q);
    assign match    = (word == expected);   // In HUNT this is seed plus one
    assign locked   = (state == LOCKED);

    always_ff @(posedge CLK) begin
        mask_q <= mask;
    end

    // Seed and expected counter
    always_ff @(posedge CLK) begin
        if (rx_valid) begin
            if (state == HUNT) begin
                expected <= word + 1'b1;       // New seed each word
            end else begin
                expected <= expected + 1'b1;   // Advances hit or miss
            end
        end
    end

    // Alignment FSM, run counters, error count
    always_ff @(posedge CLK) begin
        if (sys_rst) begin
            state     <= HUNT;
            seed_vld  <= 1'b0;
            good_cnt  <= '0;
            bad_cnt   <= '0;
            bitslip   <= 1'b0;
            err_count <= '0;
        end else begin
            bitslip <= 1'b0;                         // Single-cycle pulse
            if (mask_chg) begin
                state    <= HUNT;                    // Restart, no error charged
                seed_vld <= 1'b0;
                good_cnt <= '0;
                bad_cnt  <= '0;
            end else if (rx_valid) begin
                case (state)
                    HUNT: begin
                        if (!seed_vld) begin
                            seed_vld <= 1'b1;        // First word is the seed
                        end else if (match) begin
                            state    <= VERIFY;      // Candidate boundary
                            seed_vld <= 1'b0;
                            good_cnt <= '0;
                        end else begin
                            bitslip  <= 1'b1;        // Try next boundary
                            seed_vld <= 1'b0;
                        end
                    end
                    VERIFY: begin
                        if (!match) begin
                            state    <= HUNT;        // Any miss restarts
                            good_cnt <= '0;
                        end else begin
                            good_cnt <= good_cnt + 1'b1;
                            if (good_cnt == GOOD_W'(LOCK_GOOD - 1)) begin
                                state   <= LOCKED;
                                bad_cnt <= '0;
                            end
                        end
                    end
                    LOCKED: begin
                        if (match) begin
                            bad_cnt <= '0;           // Break the bad run
                        end else begin
                            if (err_count != '1) begin
                                err_count <= err_count + 1'b1;   // Saturates
                            end
                            if (bad_cnt == BAD_W'(UNLOCK_BAD - 1)) begin
                                state   <= HUNT;     // Boundary lost
                                bad_cnt <= '0;
                            end else begin
                                bad_cnt <= bad_cnt + 1'b1;
                            end
                        end
                    end
                    default: begin
                        state <= HUNT;
                    end
                endcase
            end
        end
    end

endmodule

/* serdes_test.sv */
`timescale 1ns/1ps

module serdes_test import serdes_test_pkg::*; (
    input  logic              CLK,
    input  logic              sys_rst,
    input  logic [WORD_W-1:0] sw,
    input  logic              in_bit,
    output logic              out_bit,
    output logic              locked,
    output logic [ERR_W-1:0]  err_count
);

    logic [WORD_W-1:0] tx_word;         // Source to serializer
    logic              tx_valid;
    logic              credit_return;   // Serializer back to source
    logic [WORD_W-1:0] rx_word;         // Deserializer to checker
    logic              rx_valid;
    logic              bitslip;         // Checker back to deserializer

    // Transmit path
    word_source i_source (
        .CLK           (CLK),
        .sys_rst       (sys_rst),
        .mask          (sw),            // Same mask as checker
        .credit_return (credit_return),
        .tx_word       (tx_word),
        .tx_valid      (tx_valid)
    );

    word_serializer i_serializer (
        .CLK           (CLK),
        .sys_rst       (sys_rst),
        .tx_word       (tx_word),
        .tx_valid      (tx_valid),
        .credit_return (credit_return),
        .ser_out       (out_bit)
    );

    // Receive path, no back-pressure
    word_deserializer i_deserializer (
        .CLK      (CLK),
        .sys_rst  (sys_rst),
        .ser_in   (in_bit),             // External loopback
        .bitslip  (bitslip),
        .rx_word  (rx_word),
        .rx_valid (rx_valid)
    );

    link_checker i_checker (
        .CLK       (CLK),
        .sys_rst   (sys_rst),
        .mask      (sw),
        .rx_word   (rx_word),
        .rx_valid  (rx_valid),
        .bitslip   (bitslip),
        .locked    (locked),
        .err_count (err_count)
    );

endmodule

/* top.sv */
`timescale 1ns/1ps

module top import serdes_test_pkg::*; (
    input  logic              CLK,
    input  logic              rst,
    input  logic [WORD_W-1:0] sw,
    output logic [ERR_W+1:0]  led,
    input  logic              in,
    output logic              out
);

    logic sys_rst;   // Stretched reset for the test unit

    // Reset stretch and blink
    reset_heartbeat i_reset_heartbeat (
        .CLK       (CLK),
        .rst       (rst),
        .sys_rst   (sys_rst),
        .heartbeat (led[0])             // Alive indicator
    );

    // Link test, status straight to LEDs
    serdes_test i_serdes_test (
        .CLK       (CLK),
        .sys_rst   (sys_rst),
        .sw        (sw),                // Word mask
        .in_bit    (in),
        .out_bit   (out),
        .locked    (led[ERR_W+1]),      // Lock on top LED
        .err_count (led[ERR_W:1])       // Error count below it
    );

endmodule

/* tb_link_monitor.sv */
`timescale 1ns/1ps

module tb_link_monitor import serdes_test_pkg::*; (
    input  logic             CLK,
    input  logic             rst,
    input  logic [ERR_W+1:0] led,
    input  logic             out_bit,
    input  logic             row_start,
    input  logic             check_req,
    input  int               row_idx,
    input  logic             exp_lock,
    input  logic [ERR_W-1:0] exp_err,
    input  logic             exp_drop,
    output int               value_errors,
    output int               other_errors,
    output int               checks
);

    logic armed     = 1'b0;   // DUT state unknown before the first edge
    int   post_rst  = 0;      // Cycles since rst fell
    logic prev_lock = 1'b0;   // led[8] one cycle back
    logic fell      = 1'b0;   // led[8] fell during the current row

    initial begin
        value_errors = 0;
        other_errors = 0;
        checks       = 0;
    end

    // Heartbeat tap from cycles counted since the stretched reset ended
    function automatic logic hb_expected(input int since_rst);
        int run;
        run = since_rst - RST_STRETCH;
        if (run < 0) begin
            return 1'b0;                         // Counter still held
        end
        return run[HEARTBEAT_BIT];
    endfunction

    task automatic value_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp, input string where);
        $display("FAILED %s = 0x%0h, expected 0x%0h (%s, t=%0t)", name, got, exp, where, $time);
        value_errors = value_errors + 1;
    endtask

    task automatic link_fault(input string msg);
        $display("Row %0d: %s (t=%0t)", row_idx, msg, $time);
        other_errors = other_errors + 1;
    endtask

    // Outputs quiet while the stretched reset is still running
    task automatic check_reset_state();
        checks = checks + 1;
        if (led[ERR_W+1] !== 1'b0) value_mismatch("led[8]", led[ERR_W+1], 0, "reset");
        if (led[ERR_W:1] !== '0) value_mismatch("led[7:1]", led[ERR_W:1], 0, "reset");
        if (out_bit !== 1'b0) value_mismatch("out", out_bit, 0, "reset");
        if (led[0] !== hb_expected(post_rst)) begin
            value_mismatch("led[0]", led[0], hb_expected(post_rst), "reset");
        end
    endtask

    // End of row, compare against the row's expected values
    task automatic compare_row();
        checks = checks + 1;
        if (exp_lock && led[ERR_W+1] !== 1'b1) begin
            link_fault("link never reached lock, led[8] still low at the end of the row");
        end else if (led[ERR_W+1] !== exp_lock) begin
            value_mismatch("led[8]", led[ERR_W+1], exp_lock, $sformatf("row %0d", row_idx));
        end
        if (led[ERR_W:1] !== exp_err) begin
            value_mismatch("led[7:1]", led[ERR_W:1], exp_err, $sformatf("row %0d", row_idx));
        end
        if (led[0] !== hb_expected(post_rst)) begin
            value_mismatch("led[0]", led[0], hb_expected(post_rst),
                           $sformatf("row %0d", row_idx));
        end
        if (exp_drop && !fell) begin
            link_fault("lock was expected to drop during the row but stayed up");
        end else if (!exp_drop && fell) begin
            link_fault("lock dropped during a row that should have kept it");
        end
    endtask

    always @(posedge CLK) begin
        armed    <= 1'b1;
        post_rst <= rst ? 0 : post_rst + 1;
        if (armed && (rst || post_rst < RST_STRETCH + 2)) begin
            check_reset_state();                 // Covers the stretch window too
        end
        prev_lock <= led[ERR_W+1];
        if (row_start) begin
            fell <= 1'b0;                        // New row, new watch
        end else if (prev_lock === 1'b1 && led[ERR_W+1] === 1'b0) begin
            fell <= 1'b1;
        end
        if (check_req) begin
            compare_row();
        end
    end

endmodule

/* tb_top.sv */
`timescale 1ns/1ps

module tb_top import serdes_test_pkg::*; ();

    localparam int CLK_PERIOD = 4;                            // ns
    localparam int LOCK_WORDS = 4 * WORD_W + LOCK_GOOD + 4;   // Lock bound in words
    localparam int NUM_ROWS   = 12;
    localparam int MARGIN_NS  = 2000;                         // Reset and row overhead

    logic              CLK;
    logic              rst;
    logic [WORD_W-1:0] sw;
    logic [ERR_W+1:0]  led;
    logic              in_bit;
    logic              out_bit;
    logic [6:0]        dline;        // Loopback channel taps
    logic [2:0]        loop_delay;   // Channel length in cycles
    logic              flip;         // Invert one line bit

    // Stimulus table, one entry per row
    logic [WORD_W-1:0] t_sw     [NUM_ROWS];
    int                t_delay  [NUM_ROWS];
    int                t_flips  [NUM_ROWS];   // Words to corrupt
    bit                t_consec [NUM_ROWS];   // Corrupt back to back
    int                t_words  [NUM_ROWS];   // Row length in words
    bit                t_lock   [NUM_ROWS];   // led[8] at row end
    int                t_inc    [NUM_ROWS];   // Error count growth
    bit                t_drop   [NUM_ROWS];   // led[8] falls in row

    logic              row_start;             // To monitor
    logic              check_req;
    int                row_idx;
    logic              exp_lock;
    logic              exp_drop;
    logic [ERR_W-1:0]  exp_err;
    int                value_errors;          // From monitor
    int                other_errors;
    int                checks;
    integer            seed;                  // Flip placement
    int                exp_err_sum;           // Running expected count
    bit                table_ready;
    int                r;

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    top i_dut (
        .CLK (CLK),
        .rst (rst),
        .sw  (sw),
        .led (led),
        .in  (in_bit),
        .out (out_bit)
    );

    tb_link_monitor i_monitor (
        .CLK          (CLK),
        .rst          (rst),
        .led          (led),
        .out_bit      (out_bit),
        .row_start    (row_start),
        .check_req    (check_req),
        .row_idx      (row_idx),
        .exp_lock     (exp_lock),
        .exp_err      (exp_err),
        .exp_drop     (exp_drop),
        .value_errors (value_errors),
        .other_errors (other_errors),
        .checks       (checks)
    );

    // Loopback channel, tap 0 is a straight wire
    always @(posedge CLK) begin
        if (rst) begin
            dline <= '0;
        end else begin
            dline <= {dline[5:0], out_bit};
        end
    end

    assign in_bit = ((loop_delay == 3'd0) ? out_bit : dline[loop_delay - 1]) ^ flip;

    task automatic add_row(input int idx, input logic [WORD_W-1:0] sw_val, input int dly,
                           input int nflip, input bit consec, input int words,
                           input bit lock, input int inc, input bit drop);
        t_sw[idx]     = sw_val;
        t_delay[idx]  = dly;
        t_flips[idx]  = nflip;
        t_consec[idx] = consec;
        t_words[idx]  = words;
        t_lock[idx]   = lock;
        t_inc[idx]    = inc;
        t_drop[idx]   = drop;
    endtask

    task automatic fill_table();
        // row, sw, delay, flips, consecutive, words, lock, error increase, lock drop
        add_row(0,  8'h00, 0, 0, 0, LOCK_WORDS, 1, 0, 0);   // First lock out of reset
        add_row(1,  8'h5a, 1, 0, 0, LOCK_WORDS, 1, 0, 1);
        add_row(2,  8'ha5, 2, 0, 0, LOCK_WORDS, 1, 0, 1);
        add_row(3,  8'h3c, 3, 0, 0, LOCK_WORDS, 1, 0, 1);
        add_row(4,  8'hc3, 4, 0, 0, LOCK_WORDS, 1, 0, 1);
        add_row(5,  8'h0f, 5, 0, 0, LOCK_WORDS, 1, 0, 1);
        add_row(6,  8'hf0, 6, 0, 0, LOCK_WORDS, 1, 0, 1);
        add_row(7,  8'h96, 7, 0, 0, LOCK_WORDS, 1, 0, 1);
        add_row(8,  8'h96, 7, 3, 0, 80, 1, 3, 0);                    // Isolated hits
        add_row(9,  8'h96, 7, UNLOCK_BAD, 1, 64, 1, UNLOCK_BAD, 1);  // Burst, relock
        add_row(10, 8'h69, 7, 0, 0, LOCK_WORDS, 1, 0, 1);            // Mask swap
        add_row(11, 8'h69, 7, 2, 0, 64, 1, 2, 0);
    endtask

    function automatic int total_words();
        int sum;
        int i;
        sum = 0;
        for (i = 0; i < NUM_ROWS; i++) begin
            sum = sum + t_words[i];
        end
        return sum;
    endfunction

    task automatic run_row(input int idx);
        int flip_at[$];   // Cycle offsets of flipped bits
        int pos;
        int bit_ofs;
        int c;
        int i;
        pos     = 4 + ($random(seed) & 7);   // Word index of first flip
        bit_ofs = $random(seed) & 7;
        for (i = 0; i < t_flips[idx]; i++) begin
            flip_at.push_back(pos * WORD_W + bit_ofs);
            pos = pos + (t_consec[idx] ? 1 : 16 + ($random(seed) & 7));
        end
        @(posedge CLK);
        sw         <= t_sw[idx];
        loop_delay <= 3'(t_delay[idx]);
        row_start  <= 1'b1;
        check_req  <= 1'b0;
        row_idx    <= idx;
        for (c = 0; c < t_words[idx] * WORD_W; c++) begin
            @(posedge CLK);
            row_start <= 1'b0;
            if (flip_at.size() != 0 && flip_at[0] == c) begin
                flip <= 1'b1;                // Single cycle only
                pos  = flip_at.pop_front();
            end else begin
                flip <= 1'b0;
            end
        end
        exp_err_sum = exp_err_sum + t_inc[idx];
        @(posedge CLK);
        flip      <= 1'b0;
        exp_lock  <= t_lock[idx];
        exp_err   <= ERR_W'(exp_err_sum);
        exp_drop  <= t_drop[idx];
        check_req <= 1'b1;                   // Monitor compares on next edge
    endtask

    initial begin
        int limit_ns;
        wait (table_ready);
        limit_ns = total_words() * WORD_W * CLK_PERIOD + MARGIN_NS;
        #(limit_ns);
        $display("Watchdog expired after %0d ns, the run did not complete", limit_ns);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        rst         = 1'b1;
        sw          = '0;
        loop_delay  = '0;
        flip        = 1'b0;
        dline       = '0;
        row_start   = 1'b0;
        check_req   = 1'b0;
        row_idx     = 0;
        exp_lock    = 1'b0;
        exp_err     = '0;
        exp_drop    = 1'b0;
        exp_err_sum = 0;
        seed        = 32'hddba;
        fill_table();
        table_ready = 1'b1;
        repeat (4) @(posedge CLK);
        rst <= 1'b0;
        repeat (RST_STRETCH + 2) @(posedge CLK);   // Stretch plus settle
        for (r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        @(posedge CLK);
        check_req <= 1'b0;
        repeat (2) @(posedge CLK);
        $display("Checks run: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0 && checks > 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
serdes_test_pkg.sv
reset_heartbeat.sv
word_source.sv
word_serializer.sv
word_deserializer.sv
link_checker.sv
serdes_test.sv
top.sv
tb_link_monitor.sv
tb_top.sv
